// File: Makefile
TOP := tb_cache_memctrl

.PHONY: sim clean

sim:
	verilator --binary --timing --assert --timescale 1ns/1ps -f build.f --top-module $(TOP) -Mdir obj_dir
	./obj_dir/V$(TOP) | awk '{ print } /Result: PASSED/ { ok = 1 } END { exit !ok }'

clean:
	rm -rf obj_dir

// File: build.f
design/cache_geom_pkg.sv
design/cache_req_pkg.sv
design/way_sram.sv
design/mem_access_arbiter.sv
design/lookup_resolve.sv
design/plru_victim_sel.sv
design/cache_memctrl.sv
verification/cache_memctrl_properties.sv
verification/tb_cache_memctrl.sv

// File: design/cache_geom_pkg.sv
package cache_geom_pkg;

    // Cache geometry
    localparam int unsigned SETS       = 64;
    localparam int unsigned WAYS       = 4;
    localparam int unsigned CL_WORDS   = 4;
    localparam int unsigned WORD_WIDTH = 64;
    localparam int unsigned TAG_WIDTH  = 20;

    // Derived widths
    localparam int unsigned SET_WIDTH      = $clog2(SETS);
    localparam int unsigned WORD_IDX_WIDTH = $clog2(CL_WORDS);
    localparam int unsigned BE_WIDTH       = WORD_WIDTH / 8;
    localparam int unsigned NLINE_WIDTH    = TAG_WIDTH + SET_WIDTH;

    // One data RAM entry per word of every line
    localparam int unsigned DATA_DEPTH = SETS * CL_WORDS;

    typedef logic [SET_WIDTH-1:0]          set_t;
    typedef logic [TAG_WIDTH-1:0]          tag_t;
    typedef logic [WORD_IDX_WIDTH-1:0]     word_idx_t;
    // Set in the low bits, tag above
    typedef logic [NLINE_WIDTH-1:0]        nline_t;
    typedef logic [WAYS-1:0]               way_vec_t;
    typedef logic [WORD_WIDTH-1:0]         data_word_t;
    typedef logic [BE_WIDTH-1:0]           be_t;
    // Set times CL_WORDS plus the word index
    typedef logic [$clog2(DATA_DEPTH)-1:0] data_addr_t;

    typedef struct packed {
        logic valid;
        tag_t tag;
    } dir_entry_t;

endpackage

// File: design/cache_memctrl.sv
module cache_memctrl (
    input  logic                        clk_i,
    input  logic                        rst_ni,
    output logic                        ready_o,

    input  logic                        dir_lookup_i,
    input  cache_req_pkg::dir_lookup_t  dir_lookup_req_i,
    input  logic                        dir_update_plru_i,
    output cache_geom_pkg::way_vec_t    hit_way_o,

    input  logic                        dir_refill_sel_victim_i,
    input  logic                        dir_refill_i,
    input  cache_req_pkg::dir_refill_t  dir_refill_req_i,
    output cache_geom_pkg::way_vec_t    victim_way_o,

    input  logic                        dir_inval_check_i,
    input  logic                        dir_inval_write_i,
    input  cache_geom_pkg::nline_t      dir_inval_nline_i,
    output logic                        inval_hit_o,

    input  logic                        data_read_i,
    input  cache_req_pkg::data_read_t   data_read_req_i,
    input  logic                        data_write_i,
    input  cache_req_pkg::data_write_t  data_write_req_i,
    input  logic                        data_refill_i,
    input  cache_req_pkg::data_refill_t data_refill_req_i,
    output cache_geom_pkg::data_word_t  data_rdata_o
);

    cache_req_pkg::dir_ram_req_t                          dir_ram;
    cache_geom_pkg::dir_entry_t                           dir_wentry;
    cache_geom_pkg::dir_entry_t [cache_geom_pkg::WAYS-1:0] dir_rentry;
    cache_req_pkg::data_ram_req_t                         data_ram;
    cache_geom_pkg::data_word_t                           data_wdata;
    cache_geom_pkg::be_t                                  data_be;
    cache_geom_pkg::data_word_t [cache_geom_pkg::WAYS-1:0] data_rword;
    cache_geom_pkg::set_t                                 hit_set;
    cache_geom_pkg::way_vec_t                             valid_vec;

    mem_access_arbiter i_arbiter (
        .clk_i, .rst_ni, .ready_o,
        .dir_lookup_i, .dir_lookup_req_i,
        .dir_refill_sel_victim_i, .dir_refill_i, .dir_refill_req_i,
        .dir_inval_check_i, .dir_inval_write_i, .dir_inval_nline_i,
        .data_read_i, .data_read_req_i, .data_write_i, .data_write_req_i,
        .data_refill_i, .data_refill_req_i,
        .hit_way_i    (hit_way_o),
        .victim_way_i (victim_way_o),
        .dir_ram_o    (dir_ram),
        .dir_wentry_o (dir_wentry),
        .data_ram_o   (data_ram),
        .data_wdata_o (data_wdata),
        .data_be_o    (data_be)
    );

    // Directory entries, byte enables unused
    way_sram #(
        .payload_t (cache_geom_pkg::dir_entry_t),
        .DEPTH     (cache_geom_pkg::SETS)
    ) i_dir_sram (
        .clk_i, .cs_i (dir_ram.cs), .we_i (dir_ram.we), .addr_i (dir_ram.addr),
        .wdata_i (dir_wentry), .be_i ('1), .rdata_o (dir_rentry)
    );

    way_sram #(
        .payload_t (cache_geom_pkg::data_word_t),
        .DEPTH     (cache_geom_pkg::DATA_DEPTH)
    ) i_data_sram (
        .clk_i, .cs_i (data_ram.cs), .we_i (data_ram.we), .addr_i (data_ram.addr),
        .wdata_i (data_wdata), .be_i (data_be), .rdata_o (data_rword)
    );

    lookup_resolve i_lookup_resolve (
        .clk_i, .rst_ni,
        .dir_lookup_i, .dir_lookup_req_i, .dir_inval_check_i, .dir_inval_nline_i,
        .dir_rentry_i (dir_rentry), .data_rword_i (data_rword),
        .hit_way_o, .inval_hit_o, .hit_set_o (hit_set), .valid_vec_o (valid_vec),
        .data_rdata_o
    );

    plru_victim_sel i_plru_victim_sel (
        .clk_i, .rst_ni,
        .updt_i (dir_update_plru_i), .updt_set_i (hit_set), .updt_way_i (hit_way_o),
        .repl_i (dir_refill_i), .repl_set_i (dir_refill_req_i.set),
        .valid_vec_i (valid_vec), .victim_way_o
    );

endmodule

// File: design/cache_req_pkg.sv
package cache_req_pkg;

    // Tag lookup of one set
    typedef struct packed {
        cache_geom_pkg::set_t set;
        cache_geom_pkg::tag_t tag;
    } dir_lookup_t;

    // New directory entry, written into the victim way
    typedef struct packed {
        cache_geom_pkg::set_t       set;
        cache_geom_pkg::dir_entry_t entry;
    } dir_refill_t;

    typedef struct packed {
        cache_geom_pkg::set_t      set;
        cache_geom_pkg::word_idx_t word;
    } data_read_t;

    // Word write into the way that hit in the previous cycle
    typedef struct packed {
        cache_geom_pkg::set_t       set;
        cache_geom_pkg::word_idx_t  word;
        cache_geom_pkg::data_word_t data;
        cache_geom_pkg::be_t        be;
    } data_write_t;

    typedef struct packed {
        cache_geom_pkg::way_vec_t   way;
        cache_geom_pkg::set_t       set;
        cache_geom_pkg::word_idx_t  word;
        cache_geom_pkg::data_word_t data;
    } data_refill_t;

    // Per-way chip selects and write enables, one shared address
    typedef struct packed {
        cache_geom_pkg::way_vec_t cs;
        cache_geom_pkg::way_vec_t we;
        cache_geom_pkg::set_t     addr;
    } dir_ram_req_t;

    typedef struct packed {
        cache_geom_pkg::way_vec_t   cs;
        cache_geom_pkg::way_vec_t   we;
        cache_geom_pkg::data_addr_t addr;
    } data_ram_req_t;

endpackage

// File: design/lookup_resolve.sv
module lookup_resolve (
    input  logic                                              clk_i,
    input  logic                                              rst_ni,
    input  logic                                              dir_lookup_i,
    input  cache_req_pkg::dir_lookup_t                        dir_lookup_req_i,
    input  logic                                              dir_inval_check_i,
    input  cache_geom_pkg::nline_t                            dir_inval_nline_i,
    input  cache_geom_pkg::dir_entry_t [cache_geom_pkg::WAYS-1:0] dir_rentry_i,
    input  cache_geom_pkg::data_word_t [cache_geom_pkg::WAYS-1:0] data_rword_i,
    output cache_geom_pkg::way_vec_t                          hit_way_o,
    output logic                                              inval_hit_o,
    output cache_geom_pkg::set_t                              hit_set_o,
    output cache_geom_pkg::way_vec_t                          valid_vec_o,
    output cache_geom_pkg::data_word_t                        data_rdata_o
);

    logic                     lookup_q;
    logic                     inval_q;
    cache_geom_pkg::set_t     set_q;
    cache_geom_pkg::tag_t     tag_q;
    cache_geom_pkg::way_vec_t match;

    // Which compare the RAM output belongs to
    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            lookup_q <= 1'b0;
            inval_q  <= 1'b0;
        end else begin
            lookup_q <= dir_lookup_i;
            inval_q  <= dir_inval_check_i & ~dir_lookup_i;
        end
    end

    // Compare address captured in the command cycle
    always_ff @(posedge clk_i) begin
        if (dir_lookup_i) begin
            set_q <= dir_lookup_req_i.set;
            tag_q <= dir_lookup_req_i.tag;
        end else if (dir_inval_check_i) begin
            set_q <= cache_geom_pkg::set_t'(dir_inval_nline_i);
            tag_q <= dir_inval_nline_i[cache_geom_pkg::NLINE_WIDTH-1:cache_geom_pkg::SET_WIDTH];
        end
    end

    for (genvar w = 0; w < cache_geom_pkg::WAYS; w++) begin : gen_cmp
        assign valid_vec_o[w] = dir_rentry_i[w].valid;
        assign match[w]       = dir_rentry_i[w].valid && (dir_rentry_i[w].tag == tag_q);
    end

    // Serves the lookup and the invalidate compare alike
    assign hit_way_o   = (lookup_q || inval_q) ? match : '0;
    assign inval_hit_o = inval_q & (|match);
    assign hit_set_o   = set_q;

    // One-hot select, zero on a miss
    always_comb begin
        data_rdata_o = '0;
        for (int w = 0; w < cache_geom_pkg::WAYS; w++) begin
            if (hit_way_o[w]) begin
                data_rdata_o = data_rdata_o | data_rword_i[w];
            end
        end
    end

endmodule

// File: design/mem_access_arbiter.sv
module mem_access_arbiter (
    input  logic                          clk_i,
    input  logic                          rst_ni,
    input  logic                          dir_lookup_i,
    input  cache_req_pkg::dir_lookup_t    dir_lookup_req_i,
    input  logic                          dir_refill_sel_victim_i,
    input  logic                          dir_refill_i,
    input  cache_req_pkg::dir_refill_t    dir_refill_req_i,
    input  logic                          dir_inval_check_i,
    input  logic                          dir_inval_write_i,
    input  cache_geom_pkg::nline_t        dir_inval_nline_i,
    input  logic                          data_read_i,
    input  cache_req_pkg::data_read_t     data_read_req_i,
    input  logic                          data_write_i,
    input  cache_req_pkg::data_write_t    data_write_req_i,
    input  logic                          data_refill_i,
    input  cache_req_pkg::data_refill_t   data_refill_req_i,
    input  cache_geom_pkg::way_vec_t      hit_way_i,
    input  cache_geom_pkg::way_vec_t      victim_way_i,
    output logic                          ready_o,
    output cache_req_pkg::dir_ram_req_t   dir_ram_o,
    output cache_geom_pkg::dir_entry_t    dir_wentry_o,
    output cache_req_pkg::data_ram_req_t  data_ram_o,
    output cache_geom_pkg::data_word_t    data_wdata_o,
    output cache_geom_pkg::be_t           data_be_o
);

    logic                 init_q;
    cache_geom_pkg::set_t init_set_q;
    cache_geom_pkg::set_t inval_set;

    function automatic cache_geom_pkg::data_addr_t word_addr(
        input cache_geom_pkg::set_t      set,
        input cache_geom_pkg::word_idx_t word
    );
        return cache_geom_pkg::data_addr_t'(set * cache_geom_pkg::CL_WORDS + word);
    endfunction

    // Sweep clears one set per cycle, ready once the last set is written
    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            init_q     <= 1'b0;
            init_set_q <= '0;
        end else if (!init_q) begin
            init_q     <= (init_set_q == cache_geom_pkg::set_t'(cache_geom_pkg::SETS - 1));
            init_set_q <= init_set_q + 1'b1;
        end
    end

    assign ready_o   = init_q;
    assign inval_set = cache_geom_pkg::set_t'(dir_inval_nline_i);

    // Directory requests, highest priority first
    always_comb begin
        dir_ram_o    = '0;
        dir_wentry_o = '0;
        case (1'b1)
            ~init_q: begin
                dir_ram_o.cs   = '1;
                dir_ram_o.we   = '1;
                dir_ram_o.addr = init_set_q;
            end
            dir_lookup_i: begin
                dir_ram_o.cs   = '1;
                dir_ram_o.addr = dir_lookup_req_i.set;
            end
            dir_refill_sel_victim_i: begin
                dir_ram_o.cs   = '1;
                dir_ram_o.addr = dir_refill_req_i.set;
            end
            // Victim comes from the read one cycle earlier
            dir_refill_i: begin
                dir_ram_o.cs   = victim_way_i;
                dir_ram_o.we   = victim_way_i;
                dir_ram_o.addr = dir_refill_req_i.set;
                dir_wentry_o   = dir_refill_req_i.entry;
            end
            dir_inval_check_i: begin
                dir_ram_o.cs   = '1;
                dir_ram_o.addr = inval_set;
            end
            // Clear the way that matched the check, written entry stays zero
            dir_inval_write_i: begin
                dir_ram_o.cs   = hit_way_i;
                dir_ram_o.we   = hit_way_i;
                dir_ram_o.addr = inval_set;
            end
            default: begin
            end
        endcase
    end

    // Data requests, nothing during the sweep
    always_comb begin
        data_ram_o   = '0;
        data_wdata_o = '0;
        data_be_o    = '0;
        case (1'b1)
            ~init_q: begin
            end
            data_refill_i: begin
                data_ram_o.cs   = data_refill_req_i.way;
                data_ram_o.we   = data_refill_req_i.way;
                data_ram_o.addr = word_addr(data_refill_req_i.set, data_refill_req_i.word);
                data_wdata_o    = data_refill_req_i.data;
                data_be_o       = '1;
            end
            // Lands in the way that hit the lookup of the previous cycle
            data_write_i: begin
                data_ram_o.cs   = hit_way_i;
                data_ram_o.we   = hit_way_i;
                data_ram_o.addr = word_addr(data_write_req_i.set, data_write_req_i.word);
                data_wdata_o    = data_write_req_i.data;
                data_be_o       = data_write_req_i.be;
            end
            data_read_i: begin
                data_ram_o.cs   = '1;
                data_ram_o.addr = word_addr(data_read_req_i.set, data_read_req_i.word);
            end
            default: begin
            end
        endcase
    end

endmodule

// File: design/plru_victim_sel.sv
module plru_victim_sel (
    input  logic                     clk_i,
    input  logic                     rst_ni,
    input  logic                     updt_i,
    input  cache_geom_pkg::set_t     updt_set_i,
    input  cache_geom_pkg::way_vec_t updt_way_i,
    input  logic                     repl_i,
    input  cache_geom_pkg::set_t     repl_set_i,
    input  cache_geom_pkg::way_vec_t valid_vec_i,
    output cache_geom_pkg::way_vec_t victim_way_o
);

    // Bit 0 is the root, bit 1 the leaf of ways 0/1, bit 2 the leaf of ways 2/3
    logic [cache_geom_pkg::SETS-1:0][2:0] tree_q;
    logic [2:0]                           repl_tree;

    // Point the path of the accessed way away from it
    function automatic logic [2:0] touch(
        input logic [2:0]               tree,
        input cache_geom_pkg::way_vec_t way
    );
        logic [2:0] t;
        t = tree;
        if (way[0] || way[1]) begin
            t[0] = 1'b1;
            t[1] = way[0];
        end else if (way[2] || way[3]) begin
            t[0] = 1'b0;
            t[2] = way[2];
        end
        return t;
    endfunction

    // The refill set is expected to stay on repl_set_i from select to write
    always_comb begin
        repl_tree    = tree_q[repl_set_i];
        victim_way_o = '0;
        if (!(&valid_vec_i)) begin
            // Descending scan leaves the lowest invalid way
            for (int w = cache_geom_pkg::WAYS - 1; w >= 0; w--) begin
                if (!valid_vec_i[w]) begin
                    victim_way_o = cache_geom_pkg::way_vec_t'(1 << w);
                end
            end
        end else if (!repl_tree[0]) begin
            victim_way_o = repl_tree[1] ? 4'b0010 : 4'b0001;
        end else begin
            victim_way_o = repl_tree[2] ? 4'b1000 : 4'b0100;
        end
    end

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            tree_q <= '0;
        end else if (repl_i) begin
            tree_q[repl_set_i] <= touch(tree_q[repl_set_i], victim_way_o);
        end else if (updt_i) begin
            // A miss leaves the state unchanged
            tree_q[updt_set_i] <= touch(tree_q[updt_set_i], updt_way_i);
        end
    end

endmodule

// File: design/way_sram.sv
module way_sram #(
    parameter type         payload_t = logic,
    parameter int unsigned DEPTH     = 2
) (
    input  logic                                clk_i,
    input  cache_geom_pkg::way_vec_t            cs_i,
    input  cache_geom_pkg::way_vec_t            we_i,
    input  logic [$clog2(DEPTH)-1:0]            addr_i,
    input  payload_t                            wdata_i,
    input  cache_geom_pkg::be_t                 be_i,
    output payload_t [cache_geom_pkg::WAYS-1:0] rdata_o
);

    localparam int unsigned PAYLOAD_WIDTH = $bits(payload_t);

    logic [PAYLOAD_WIDTH-1:0] wbits;

    assign wbits = wdata_i;

    for (genvar w = 0; w < cache_geom_pkg::WAYS; w++) begin : gen_bank
        logic [PAYLOAD_WIDTH-1:0] mem_q [DEPTH];
        logic [PAYLOAD_WIDTH-1:0] rdata_q;

        // Read data holds until the next read of this bank
        always_ff @(posedge clk_i) begin
            if (cs_i[w]) begin
                if (we_i[w]) begin
                    for (int b = 0; b < PAYLOAD_WIDTH; b++) begin
                        if (be_i[b / 8]) begin
                            mem_q[addr_i][b] <= wbits[b];
                        end
                    end
                end else begin
                    rdata_q <= mem_q[addr_i];
                end
            end
        end

        assign rdata_o[w] = payload_t'(rdata_q);
    end

endmodule

// File: verification/cache_memctrl_properties.sv
module cache_memctrl_properties (
    input logic clk_i,
    input logic rst_ni,
    input logic ready_o,
    input logic dir_lookup_i,
    input logic dir_refill_sel_victim_i,
    input logic dir_refill_i,
    input logic dir_inval_check_i,
    input logic dir_inval_write_i,
    input logic data_read_i,
    input logic data_write_i,
    input logic data_refill_i
);
    timeunit 1ns;
    timeprecision 1ps;

    logic [4:0] dir_strobes;
    logic [2:0] data_strobes;

    // Replacement update rides along with a lookup hit, so it is not counted
    assign dir_strobes  = {dir_lookup_i, dir_refill_sel_victim_i, dir_refill_i,
                           dir_inval_check_i, dir_inval_write_i};
    assign data_strobes = {data_read_i, data_write_i, data_refill_i};

    dir_strobes_onehot: assert property (
        @(posedge clk_i) disable iff (!rst_ni) $onehot0(dir_strobes)
    ) else $error("More than one directory command in the same cycle");

    data_strobes_onehot: assert property (
        @(posedge clk_i) disable iff (!rst_ni) $onehot0(data_strobes)
    ) else $error("More than one data command in the same cycle");

    ready_stays_high: assert property (
        @(posedge clk_i) disable iff (!rst_ni) ready_o |=> ready_o
    ) else $error("ready_o fell without a reset");

endmodule

bind cache_memctrl cache_memctrl_properties i_properties (.*);

// File: verification/tb_cache_memctrl.sv
module tb_cache_memctrl;
    timeunit 1ns;
    timeprecision 1ps;

    localparam int TEST_SET      = 21;
    localparam int READY_TIMEOUT = 200;

    logic clk_i, rst_ni, ready_o, inval_hit_o;
    logic dir_lookup_i, dir_update_plru_i, dir_refill_sel_victim_i, dir_refill_i;
    logic dir_inval_check_i, dir_inval_write_i, data_read_i, data_write_i, data_refill_i;
    cache_req_pkg::dir_lookup_t  dir_lookup_req_i;
    cache_req_pkg::dir_refill_t  dir_refill_req_i;
    cache_geom_pkg::nline_t      dir_inval_nline_i;
    cache_req_pkg::data_read_t   data_read_req_i;
    cache_req_pkg::data_write_t  data_write_req_i;
    cache_req_pkg::data_refill_t data_refill_req_i;
    cache_geom_pkg::way_vec_t    hit_way_o, victim_way_o;
    cache_geom_pkg::data_word_t  data_rdata_o;

    int     errors;
    int     timeouts;
    integer seed;

    // Reference model, zero state matches the cache after the init sweep
    bit                         m_valid [64][4];
    bit                         m_root [64];
    bit                         m_leaf [64][2];
    cache_geom_pkg::tag_t       m_tag [64][4];
    cache_geom_pkg::data_word_t m_data [64][4][4];

    cache_memctrl i_cache_memctrl (.*);

    initial begin
        clk_i = 1'b0;
        forever #10 clk_i = ~clk_i;
    end

    task automatic expect_value(string what, logic [63:0] got, logic [63:0] exp);
        assert (got === exp) else begin
            errors++;
            $display("MISMATCH at %0t ns: %s is %h, expected %h", $time, what, got, exp);
        end
    endtask

    task automatic clear_strobes();
        dir_lookup_i            = 1'b0;
        dir_update_plru_i       = 1'b0;
        dir_refill_sel_victim_i = 1'b0;
        dir_refill_i            = 1'b0;
        dir_inval_check_i       = 1'b0;
        dir_inval_write_i       = 1'b0;
        data_read_i             = 1'b0;
        data_write_i            = 1'b0;
        data_refill_i           = 1'b0;
    endtask

    // Inputs change only on the falling edge
    task automatic next_cycle();
        @(negedge clk_i);
        clear_strobes();
    endtask

    // Lowest invalid way first, else follow the tree
    function automatic int victim_of(int set_idx);
        for (int w = 0; w < 4; w++) begin
            if (!m_valid[set_idx][w]) begin
                return w;
            end
        end
        return 2 * int'(m_root[set_idx]) + int'(m_leaf[set_idx][m_root[set_idx]]);
    endfunction

    // Path bits point away from the accessed way
    task automatic touch_tree(int set_idx, int way);
        m_root[set_idx]           = (way < 2);
        m_leaf[set_idx][way / 2]  = (way % 2 == 0);
    endtask

    function automatic int hit_way_of(int set_idx, cache_geom_pkg::tag_t tag);
        for (int w = 0; w < 4; w++) begin
            if (m_valid[set_idx][w] && m_tag[set_idx][w] == tag) begin
                return w;
            end
        end
        return -1;
    endfunction

    task automatic issue_lookup(int set_idx, cache_geom_pkg::tag_t tag, int word);
        dir_lookup_i         = 1'b1;
        dir_lookup_req_i.set = cache_geom_pkg::set_t'(set_idx);
        dir_lookup_req_i.tag = tag;
        data_read_i          = 1'b1;
        data_read_req_i.set  = cache_geom_pkg::set_t'(set_idx);
        data_read_req_i.word = cache_geom_pkg::word_idx_t'(word);
    endtask

    task automatic compare_lookup(int set_idx, cache_geom_pkg::tag_t tag, int word, bit with_data);
        int w;
        w = hit_way_of(set_idx, tag);
        expect_value("hit_way_o", 64'(hit_way_o), (w < 0) ? 64'(0) : 64'(1) << w);
        if (with_data) begin
            expect_value("data_rdata_o", data_rdata_o, (w < 0) ? 64'(0) : m_data[set_idx][w][word]);
        end
    endtask

    task automatic select_victim(int set_idx, output int way);
        dir_refill_sel_victim_i = 1'b1;
        dir_refill_req_i.set    = cache_geom_pkg::set_t'(set_idx);
        next_cycle();
        way = victim_of(set_idx);
        expect_value("victim_way_o", 64'(victim_way_o), 64'(1) << way);
    endtask

    task automatic check_ready_after_reset();
        int cycles;
        cycles = 0;
        repeat (8) @(negedge clk_i);
        expect_value("ready_o in reset", 64'(ready_o), 64'(0));
        rst_ni = 1'b1;
        while (!ready_o && cycles < READY_TIMEOUT) begin
            @(negedge clk_i);
            cycles++;
        end
        if (!ready_o) begin
            timeouts++;
            $display("Timeout: ready_o still low %0d cycles after reset", READY_TIMEOUT);
        end else begin
            assert (cycles >= 64 && cycles <= 70) else begin
                errors++;
                $display("MISMATCH at %0t ns: ready_o rose after %0d cycles", $time, cycles);
            end
            issue_lookup(TEST_SET, cache_geom_pkg::tag_t'($random(seed)), 0);
            next_cycle();
            compare_lookup(TEST_SET, dir_lookup_req_i.tag, 0, 1'b1);
        end
    endtask

    task automatic fill_set_ways(int set_idx);
        int way;
        for (int i = 0; i < 4; i++) begin
            select_victim(set_idx, way);
            expect_value("victim order", 64'(victim_way_o), 64'(1) << i);
            dir_refill_i                 = 1'b1;
            dir_refill_req_i.entry.valid = 1'b1;
            dir_refill_req_i.entry.tag   = cache_geom_pkg::tag_t'($random(seed));
            m_valid[set_idx][way] = 1'b1;
            m_tag[set_idx][way]   = dir_refill_req_i.entry.tag;
            touch_tree(set_idx, way);
            next_cycle();
        end
        for (int w = 0; w < 4; w++) begin
            issue_lookup(set_idx, m_tag[set_idx][w], 0);
            next_cycle();
            compare_lookup(set_idx, m_tag[set_idx][w], 0, 1'b0);
        end
    endtask

    task automatic read_refilled_words(int set_idx);
        for (int k = 0; k < 16; k++) begin
            data_refill_i          = 1'b1;
            data_refill_req_i.way  = cache_geom_pkg::way_vec_t'(1 << (k % 4));
            data_refill_req_i.set  = cache_geom_pkg::set_t'(set_idx);
            data_refill_req_i.word = cache_geom_pkg::word_idx_t'(k / 4);
            data_refill_req_i.data = {$random(seed), $random(seed)};
            m_data[set_idx][k % 4][k / 4] = data_refill_req_i.data;
            next_cycle();
        end
        // One lookup per cycle, each line differs from the one before
        for (int k = 0; k < 16; k++) begin
            issue_lookup(set_idx, m_tag[set_idx][k % 4], k / 4);
            next_cycle();
            compare_lookup(set_idx, m_tag[set_idx][k % 4], k / 4, 1'b1);
        end
    endtask

    task automatic write_partial_bytes(int set_idx, int way, int word);
        issue_lookup(set_idx, m_tag[set_idx][way], word);
        next_cycle();
        compare_lookup(set_idx, m_tag[set_idx][way], word, 1'b1);
        data_write_i          = 1'b1;
        data_write_req_i.set  = cache_geom_pkg::set_t'(set_idx);
        data_write_req_i.word = cache_geom_pkg::word_idx_t'(word);
        data_write_req_i.data = {$random(seed), $random(seed)};
        data_write_req_i.be   = 8'b0110_1001;
        for (int b = 0; b < 8; b++) begin
            if (data_write_req_i.be[b]) begin
                m_data[set_idx][way][word][8*b +: 8] = data_write_req_i.data[8*b +: 8];
            end
        end
        next_cycle();
        issue_lookup(set_idx, m_tag[set_idx][way], word);
        next_cycle();
        compare_lookup(set_idx, m_tag[set_idx][way], word, 1'b1);
    endtask

    task automatic follow_plru_order(int set_idx);
        int way;
        int victim;
        repeat (8) begin
            way = int'($unsigned($random(seed)) % 4);
            issue_lookup(set_idx, m_tag[set_idx][way], 0);
            next_cycle();
            compare_lookup(set_idx, m_tag[set_idx][way], 0, 1'b1);
            dir_update_plru_i = 1'b1;
            touch_tree(set_idx, way);
            next_cycle();
            select_victim(set_idx, victim);
        end
    endtask

    task automatic invalidate_line(int set_idx, int way);
        int victim;
        dir_inval_check_i = 1'b1;
        dir_inval_nline_i = {m_tag[set_idx][way], cache_geom_pkg::set_t'(set_idx)};
        next_cycle();
        expect_value("inval_hit_o present", 64'(inval_hit_o), 64'(1));
        dir_inval_write_i     = 1'b1;
        m_valid[set_idx][way] = 1'b0;
        next_cycle();
        // Same line again, now absent
        dir_inval_check_i = 1'b1;
        next_cycle();
        expect_value("inval_hit_o absent", 64'(inval_hit_o), 64'(0));
        issue_lookup(set_idx, m_tag[set_idx][way], 0);
        next_cycle();
        compare_lookup(set_idx, m_tag[set_idx][way], 0, 1'b1);
        select_victim(set_idx, victim);
        expect_value("victim after invalidate", 64'(victim_way_o), 64'(1) << way);
    endtask

    initial begin
        seed     = 32'h316ef2e4;
        errors   = 0;
        timeouts = 0;
        rst_ni   = 1'b0;
        clear_strobes();
        dir_lookup_req_i  = '0;
        dir_refill_req_i  = '0;
        dir_inval_nline_i = '0;
        data_read_req_i   = '0;
        data_write_req_i  = '0;
        data_refill_req_i = '0;
        check_ready_after_reset();
        if (timeouts == 0) begin
            fill_set_ways(TEST_SET);
            read_refilled_words(TEST_SET);
            write_partial_bytes(TEST_SET, 2, 1);
            follow_plru_order(TEST_SET);
            invalidate_line(TEST_SET, 1);
        end
        $display("Errors: %0d mismatches, %0d timeouts", errors, timeouts);
        if (errors == 0 && timeouts == 0) begin
            $display("Result: PASSED");
        end else begin
            $display("Result: FAILED");
        end
        $finish;
    end

endmodule
